// ==== verification/rename_sva.sv ====
// bound checks on credits, output validity, allocated registers and free list pushes of the rename top
`timescale 1ns/1ps
`default_nettype none

module rename_sva (
  input wire                                    i_clock,
  input wire                                    i_reset,
  input wire [rename_pkg::CREDIT_W-1:0]         i_credit,
  input wire                                    i_out_valid,
  input wire [rename_pkg::GROUP_WIDTH-1:0]      i_query_rename,
  input wire [rename_pkg::PREG_W-1:0]           i_prd0,
  input wire [rename_pkg::PREG_W-1:0]           i_prd1,
  input wire                                    i_push,
  input wire [rename_pkg::PREG_W:0]             i_free_count
);
  import rename_pkg::*;

  credit_bounded: assert property (@(posedge i_clock) disable iff (i_reset)
    i_credit <= CREDIT_MAX) else $error("credit count above its maximum");

  // the group was accepted two edges before it shows on the outputs
  out_needs_credit: assert property (@(posedge i_clock) disable iff (i_reset)
    i_out_valid |-> ($past(i_credit, 2) != '0)) else $error("output group without a credit");

  prd0_nonzero: assert property (@(posedge i_clock) disable iff (i_reset)
    i_query_rename[0] |=> (i_prd0 != '0)) else $error("slot 0 renamed to physical 0");

  prd1_nonzero: assert property (@(posedge i_clock) disable iff (i_reset)
    i_query_rename[1] |=> (i_prd1 != '0)) else $error("slot 1 renamed to physical 0");

  no_push_when_full: assert property (@(posedge i_clock) disable iff (i_reset)
    i_push |-> (i_free_count != PHYS_REGS)) else $error("push into a full free list");

endmodule

bind rename_top rename_sva sva_i (
  .i_clock(i_clock), .i_reset(i_reset), .i_credit(credit_q), .i_out_valid(o_out_valid),
  .i_query_rename(query_rename), .i_prd0(o_prd[0]), .i_prd1(o_prd[1]),
  .i_push(i_free_valid), .i_free_count(free_count)
);

`default_nettype wire

// ==== verification/rename_tb.sv ====
// testbench for the rename top, applies a table of groups and checks against a reference map and free FIFO
`timescale 1ns/1ps
`default_nettype none

module rename_tb;
  import rename_pkg::*;

  typedef struct packed {
    logic [2:0]      test;
    logic [1:0]      writes;
    logic [1:0]      jumps;
    logic [1:0][4:0] rd;
    logic [1:0][4:0] rs1;
    logic [1:0][4:0] rs2;
    logic            tag;
    logic            expect_stall;
    logic            push_on_stall;   // free a register once the row has waited
    logic            credit_on_stall; // return one credit once the row has waited
    logic [5:0]      free_preg;
  } row_t;

  typedef struct {
    logic [5:0]   prd [2];
    logic [5:0]   prs1 [2];
    logic [5:0]   prs2 [2];
    logic [5:0]   old_prd [2];
    instr_class_t cls [2];
    logic         branch;
    logic         tag;
  } expect_t;

  localparam int STALL_WAIT = 8;

  logic clock = 1'b0;
  logic reset;
  logic valid [2];
  logic [31:0] address [2];
  logic [31:0] immediate [2];
  instr_class_t cls [2];
  logic [4:0] rd [2];
  logic [4:0] rs1 [2];
  logic [4:0] rs2 [2];
  logic writes [2];
  logic jumps [2];
  logic tag, credit_return, free_valid;
  logic [5:0] free_preg;
  logic ready, out_valid, branch, out_tag;
  logic slot_valid [2];
  logic [5:0] prd [2];
  logic [5:0] prs1 [2];
  logic [5:0] prs2 [2];
  logic [5:0] old_prd [2];
  instr_class_t out_class [2];

  row_t rows [$];
  expect_t exp_q [$];
  logic [5:0] map_m [32];
  logic [5:0] free_m [$];
  logic [31:0] rng = 32'h2b5c;
  logic auto_return = 1'b1;
  int return_pending = 0;
  int errors = 0;
  int checks = 0;
  int groups_seen = 0;
  int cycles = 0;
  int limit = 100000;

  always #4 clock = ~clock;

  rename_top dut_i (
    .i_clock(clock), .i_reset(reset), .i_valid(valid), .i_address(address),
    .i_immediate(immediate), .i_class(cls), .i_rd(rd), .i_rs1(rs1), .i_rs2(rs2),
    .i_writes(writes), .i_jumps(jumps), .i_tag(tag), .i_credit_return(credit_return),
    .i_free_valid(free_valid), .i_free_preg(free_preg), .o_ready(ready),
    .o_out_valid(out_valid), .o_branch(branch), .o_tag(out_tag), .o_slot_valid(slot_valid),
    .o_prd(prd), .o_prs1(prs1), .o_prs2(prs2), .o_old_prd(old_prd), .o_class(out_class)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic add_group(input int t, input logic [1:0] w, input logic [4:0] d0, a0, b0,
                           input logic [4:0] d1, a1, b1, input logic [1:0] j, input logic g);
    row_t r;
    r = '0;
    r.test = t;
    r.writes = w;
    r.jumps = j;
    r.rd = {d1, d0};
    r.rs1 = {a1, a0};
    r.rs2 = {b1, b0};
    r.tag = g;
    rows.push_back(r);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // reference model, updated when a group is accepted
  ////////////////////////////////////////////////////////////////////////

  task automatic predict(input row_t r);
    expect_t e;
    e.branch = |r.jumps;
    e.tag = r.tag;
    for (int s = 0; s < 2; s++) begin
      e.cls[s] = r.jumps[s] ? CLASS_BRANCH : (r.writes[s] ? CLASS_ALU : CLASS_STORE);
      e.prs1[s] = map_m[r.rs1[s]];  // slot 1 sees slot 0's update, which is the forwarding
      e.prs2[s] = map_m[r.rs2[s]];
      e.old_prd[s] = map_m[r.rd[s]];
      e.prd[s] = '0;
      if (r.writes[s] && r.rd[s] != 0) begin
        e.prd[s] = free_m.pop_front();
        map_m[r.rd[s]] = e.prd[s];
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic apply_row(input row_t r);
    int stall;
    int need;
    logic released;
    stall = 0;
    released = 1'b0;
    need = (r.writes[0] && r.rd[0] != 0) + (r.writes[1] && r.rd[1] != 0);
    @(posedge clock);
    for (int s = 0; s < 2; s++) begin
      rng = xorshift(rng);
      address[s] <= rng;
      rng = xorshift(rng);
      immediate[s] <= rng;
      valid[s] <= 1'b1;
      cls[s] <= r.jumps[s] ? CLASS_BRANCH : (r.writes[s] ? CLASS_ALU : CLASS_STORE);
      rd[s] <= r.rd[s];
      rs1[s] <= r.rs1[s];
      rs2[s] <= r.rs2[s];
      writes[s] <= r.writes[s];
      jumps[s] <= r.jumps[s];
    end
    tag <= r.tag;
    @(negedge clock);
    check_value("o_ready", ready, !(r.expect_stall || free_m.size() < need));
    while (!ready) begin
      stall++;
      if (stall == STALL_WAIT) begin
        released = 1'b1;
        if (r.push_on_stall) begin
          @(posedge clock);
          free_valid <= 1'b1;
          free_preg <= r.free_preg;
          free_m.push_back(r.free_preg);
          @(posedge clock);
          free_valid <= 1'b0;
        end else if (r.credit_on_stall) begin
          return_pending++;
        end else begin
          errors++;
          $display("group held with nothing planned to release it");
        end
      end
      @(negedge clock);
    end
    if (stall > 0 && !released) begin
      errors++;
      $display("o_ready rose before a register or credit was released");
    end
    predict(r);
  endtask

  task automatic finish_test(input string name, input int err_start);
    @(posedge clock);
    valid[0] <= 1'b0;
    valid[1] <= 1'b0;
    while (exp_q.size() != 0) @(posedge clock);
    repeat (6) @(posedge clock);  // let credit returns settle
    $display("test %s done, %0d errors", name, errors - err_start);
  endtask

  // output monitor, sampled away from the driving edge
  always @(negedge clock) begin
    expect_t e;
    if (!reset && out_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("output group arrived with none expected");
      end else begin
        e = exp_q.pop_front();
        groups_seen++;
        for (int s = 0; s < 2; s++) begin
          check_value($sformatf("o_slot_valid[%0d]", s), slot_valid[s], 1'b1);
          check_value($sformatf("o_prd[%0d]", s), prd[s], e.prd[s]);
          check_value($sformatf("o_prs1[%0d]", s), prs1[s], e.prs1[s]);
          check_value($sformatf("o_prs2[%0d]", s), prs2[s], e.prs2[s]);
          check_value($sformatf("o_old_prd[%0d]", s), old_prd[s], e.old_prd[s]);
          check_value($sformatf("o_class[%0d]", s), out_class[s], e.cls[s]);
        end
        check_value("o_branch", branch, e.branch);
        check_value("o_tag", out_tag, e.tag);
        if (auto_return) return_pending++;  // dispatch drains the group and hands back its credit
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (return_pending > 0) begin
      credit_return <= 1'b1;
      return_pending--;
    end else begin
      credit_return <= 1'b0;
    end
    if (cycles >= limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    int g0;
    int e0;
    string names [7];
    names = '{"", "reset_mapping", "fifo_allocation", "forwarding", "dest_x0",
              "free_exhaustion", "credit_exhaustion"};
    reset = 1'b1;
    tag = 1'b0;
    credit_return = 1'b0;
    free_valid = 1'b0;
    free_preg = '0;
    for (int s = 0; s < 2; s++) begin
      valid[s] = 1'b0;
      address[s] = '0;
      immediate[s] = '0;
      cls[s] = CLASS_ALU;
      rd[s] = '0;
      rs1[s] = '0;
      rs2[s] = '0;
      writes[s] = 1'b0;
      jumps[s] = 1'b0;
    end
    for (int i = 0; i < 32; i++) map_m[i] = i;
    for (int i = 32; i < 64; i++) free_m.push_back(i);

    add_group(1, 2'b00, 3, 1, 2, 4, 5, 6, 2'b00, 0);
    add_group(1, 2'b00, 31, 30, 29, 0, 7, 8, 2'b00, 1);
    add_group(2, 2'b11, 1, 0, 0, 2, 0, 0, 2'b00, 0);
    add_group(2, 2'b11, 3, 0, 0, 4, 0, 0, 2'b00, 0);
    add_group(2, 2'b00, 0, 1, 4, 0, 2, 3, 2'b00, 0);
    add_group(3, 2'b11, 5, 1, 2, 6, 5, 5, 2'b10, 1);
    add_group(3, 2'b00, 0, 5, 6, 0, 0, 0, 2'b01, 0);
    add_group(4, 2'b11, 0, 1, 1, 7, 0, 0, 2'b00, 0);
    add_group(4, 2'b11, 8, 2, 2, 0, 8, 7, 2'b00, 0);
    for (int k = 0; k < 12; k++) add_group(5, 2'b11, 10 + k % 10, k, 1, 20 + k % 10, 2, k, 0, 0);
    add_group(5, 2'b01, 9, 3, 4, 0, 0, 0, 2'b00, 0);
    rows[rows.size() - 1].push_on_stall = 1'b1;
    rows[rows.size() - 1].free_preg = 6'd2;
    add_group(5, 2'b00, 0, 9, 1, 0, 9, 9, 2'b00, 0);
    for (int k = 0; k < 6; k++) begin
      add_group(6, 2'b00, 0, k, k + 1, 0, k + 2, k + 3, 2'b00, 0);
      rows[rows.size() - 1].expect_stall = (k >= CREDIT_MAX);
      rows[rows.size() - 1].credit_on_stall = (k >= CREDIT_MAX);
    end
    limit = rows.size() * 20 + 100;

    repeat (2) @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);

    for (int t = 1; t <= 6; t++) begin
      e0 = errors;
      g0 = groups_seen;
      if (t == 6) begin
        auto_return = 1'b0;
        @(negedge clock);
        return_pending++;  // a return while every credit is home must not raise the count
        repeat (3) @(posedge clock);
      end
      foreach (rows[i]) begin
        if (rows[i].test == t) apply_row(rows[i]);
      end
      finish_test(names[t], e0);
      if (t == 6) check_value("groups released", groups_seen - g0, 6);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/rename_pkg.sv
verilog/instr_info_if.sv
verilog/rename_stage.sv
verilog/alias_table.sv
verilog/free_list.sv
verilog/rename_top.sv
verification/rename_sva.sv
verification/rename_tb.sv

// ==== verilog/alias_table.sv ====
// architectural to physical register map with two-slot lookup, in-group forwarding and update
`timescale 1ns/1ps
`default_nettype none

module alias_table (
  input  wire                                 i_clock,
  input  wire                                 i_reset,
  input  wire rename_pkg::arch_regs_t         i_query_regs [rename_pkg::GROUP_WIDTH],
  input  wire [rename_pkg::GROUP_WIDTH-1:0]   i_query_rename,
  input  wire [rename_pkg::PREG_W-1:0]        i_alloc_preg [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::PREG_W-1:0]       o_prs1 [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::PREG_W-1:0]       o_prs2 [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::PREG_W-1:0]       o_old_prd [rename_pkg::GROUP_WIDTH]
);
  import rename_pkg::*;

  logic [PREG_W-1:0] map_q [ARCH_REGS];

  logic fwd_rs1;
  logic fwd_rs2;
  logic fwd_rd;

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  // slot 1 is younger and must see slot 0's new destination
  assign fwd_rs1 = i_query_rename[0] && (i_query_regs[1].rs1 == i_query_regs[0].rd);
  assign fwd_rs2 = i_query_rename[0] && (i_query_regs[1].rs2 == i_query_regs[0].rd);
  assign fwd_rd  = i_query_rename[0] && (i_query_regs[1].rd == i_query_regs[0].rd);

  always_comb begin
    o_prs1[0]    = map_q[i_query_regs[0].rs1];
    o_prs2[0]    = map_q[i_query_regs[0].rs2];
    o_old_prd[0] = map_q[i_query_regs[0].rd];

    o_prs1[1] = fwd_rs1 ? i_alloc_preg[0] : map_q[i_query_regs[1].rs1];
    o_prs2[1] = fwd_rs2 ? i_alloc_preg[0] : map_q[i_query_regs[1].rs2];

    // same rd twice in a group, so slot 1 frees slot 0's register at retire
    o_old_prd[1] = fwd_rd ? i_alloc_preg[0] : map_q[i_query_regs[1].rd];
  end

  //////////////////////////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= PREG_W'(i);  // identity map, x0 lands on physical 0
      end
    end else begin
      if (i_query_rename[0] && (i_query_regs[0].rd != '0)) begin
        map_q[i_query_regs[0].rd] <= i_alloc_preg[0];
      end
      // written second so slot 1 wins on a shared rd
      if (i_query_rename[1] && (i_query_regs[1].rd != '0)) begin
        map_q[i_query_regs[1].rd] <= i_alloc_preg[1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/free_list.sv ====
// circular FIFO of free physical registers, two pops and one push per cycle, with a fill count
`timescale 1ns/1ps
`default_nettype none

module free_list (
  input  wire                                i_clock,
  input  wire                                i_reset,
  input  wire  [rename_pkg::GROUP_WIDTH-1:0] i_pop,
  input  wire                                i_push,
  input  wire  [rename_pkg::PREG_W-1:0]      i_push_preg,
  output logic [rename_pkg::PREG_W-1:0]      o_alloc_preg [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::PREG_W:0]        o_count
);
  import rename_pkg::*;

  logic [PREG_W-1:0] mem_q [PHYS_REGS];
  logic [PREG_W-1:0] head_q;
  logic [PREG_W-1:0] tail_q;
  logic [PREG_W:0]   count_q;

  logic [PREG_W-1:0] head_next;
  logic [1:0]        pop_count;
  logic              push_ok;

  assign head_next = head_q + PREG_W'(1);  // pointers wrap on their own width
  assign pop_count = {1'b0, i_pop[0]} + {1'b0, i_pop[1]};
  assign push_ok   = i_push && (count_q != PHYS_REGS[PREG_W:0]);  // full list drops the push

  // slot 1 takes the head when slot 0 does not allocate
  assign o_alloc_preg[0] = mem_q[head_q];
  assign o_alloc_preg[1] = i_pop[0] ? mem_q[head_next] : mem_q[head_q];
  assign o_count         = count_q;

  //////////////////////////////////////////////////////////////////////
  // pointers and storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      head_q  <= '0;
      tail_q  <= FREE_RESET_COUNT[PREG_W-1:0];
      count_q <= FREE_RESET_COUNT[PREG_W:0];
      for (int i = 0; i < FREE_RESET_COUNT; i++) begin
        mem_q[i] <= PREG_W'(FREE_FIRST + i);
      end
    end else begin
      if (push_ok) begin
        mem_q[tail_q] <= i_push_preg;
        tail_q        <= tail_q + PREG_W'(1);
      end
      head_q  <= head_q + {{(PREG_W - 2){1'b0}}, pop_count};
      count_q <= count_q + {{PREG_W{1'b0}}, push_ok} - {{(PREG_W - 1){1'b0}}, pop_count};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/instr_info_if.sv ====
// one decoded two-slot instruction group with its speculation tag, driven by the top and read by rename
`timescale 1ns/1ps
`default_nettype none

interface instr_info_if;
  import rename_pkg::*;

  instr_info_t slot [GROUP_WIDTH];  // slot 0 is older in program order
  logic        tag;

  // producer side, filled from the decoder ports
  modport src (
    output slot,
    output tag
  );

  // consumer side, the rename stage
  modport snk (
    input slot,
    input tag
  );

endinterface

`default_nettype wire

// ==== verilog/rename_pkg.sv ====
// shared sizes, types and reset constants for the two-wide register rename slice, import where needed
`default_nettype none

package rename_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int ARCH_REGS   = 32;
  localparam int PHYS_REGS   = 64;
  localparam int AREG_W      = 5;
  localparam int PREG_W      = 6;
  localparam int GROUP_WIDTH = 2;
  localparam int CREDIT_MAX  = 4;  // groups the dispatch buffer can hold
  localparam int CREDIT_W    = $clog2(CREDIT_MAX + 1);

  // after reset the upper half of the physical file is free
  localparam int FREE_FIRST       = ARCH_REGS;
  localparam int FREE_RESET_COUNT = PHYS_REGS - ARCH_REGS;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    CLASS_ALU,
    CLASS_LOAD,
    CLASS_STORE,
    CLASS_BRANCH,
    CLASS_JUMP,
    CLASS_SYSTEM
  } instr_class_t;

  typedef struct packed {
    logic [AREG_W-1:0] rd;
    logic [AREG_W-1:0] rs1;
    logic [AREG_W-1:0] rs2;
  } arch_regs_t;

  typedef struct packed {
    logic         valid;
    logic [31:0]  address;
    logic [31:0]  immediate;
    instr_class_t instr_class;
    arch_regs_t   regs;
    logic         writes;  // slot writes rd
    logic         jumps;   // branch or jump, may redirect fetch
  } instr_info_t;

  typedef struct packed {
    logic              valid;
    logic [31:0]       address;
    logic [31:0]       immediate;
    instr_class_t      instr_class;
    logic [PREG_W-1:0] prd;
    logic [PREG_W-1:0] prs1;
    logic [PREG_W-1:0] prs2;
    logic [PREG_W-1:0] old_prd;  // released when this slot retires
    logic              writes;
    logic              jumps;
  } renamed_t;

  localparam arch_regs_t  REGS_CLEAR    = '0;
  localparam instr_info_t INSTR_CLEAR   = '0;
  localparam renamed_t    RENAMED_CLEAR = '0;

endpackage

`default_nettype wire

// ==== verilog/rename_stage.sv ====
// rename front stage that checks free registers and credits, then latches the query and the group
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
  input  wire                                   i_clock,
  input  wire                                   i_reset,
  input  wire  [rename_pkg::PREG_W:0]           i_free_count,
  input  wire                                   i_credit_ok,
  instr_info_if.snk                             i_group,
  output logic                                  o_ready,
  output rename_pkg::arch_regs_t                o_query_regs [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::GROUP_WIDTH-1:0]    o_query_rename,
  output logic                                  o_query_tag,
  output rename_pkg::instr_info_t               o_pass [rename_pkg::GROUP_WIDTH]
);
  import rename_pkg::*;

  logic [GROUP_WIDTH-1:0] wants_reg;
  logic [1:0]             need_count;
  logic [1:0]             pending_count;
  logic [PREG_W:0]        free_avail;
  logic                   capacity_ok;
  logic                   started_q;

  //////////////////////////////////////////////////////////////////////
  // capacity check
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    need_count    = '0;
    pending_count = '0;
    for (int s = 0; s < GROUP_WIDTH; s++) begin
      // x0 is hardwired and never takes a new register
      wants_reg[s]  = i_group.slot[s].valid && i_group.slot[s].writes &&
                      (i_group.slot[s].regs.rd != '0);
      need_count    = need_count + {1'b0, wants_reg[s]};
      pending_count = pending_count + {1'b0, o_query_rename[s]};
    end
  end

  // the latched query pops its registers on the coming edge, so they are already spoken for
  assign free_avail  = i_free_count - {{(PREG_W - 1){1'b0}}, pending_count};
  assign capacity_ok = free_avail >= {{(PREG_W - 1){1'b0}}, need_count};
  assign o_ready     = started_q && i_credit_ok && capacity_ok;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      started_q <= 1'b0;  // hold off the source for the first cycle out of reset
    end else begin
      started_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // query and pass-through registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int s = 0; s < GROUP_WIDTH; s++) begin
        o_query_regs[s]   <= REGS_CLEAR;
        o_query_rename[s] <= 1'b0;
        o_pass[s]         <= INSTR_CLEAR;
      end
      o_query_tag <= 1'b0;
    end else if (o_ready) begin
      for (int s = 0; s < GROUP_WIDTH; s++) begin
        o_query_regs[s]   <= i_group.slot[s].regs;
        o_query_rename[s] <= wants_reg[s];
        o_pass[s]         <= i_group.slot[s];
      end
      o_query_tag <= i_group.tag;  // tag rides with the query
    end else begin
      // source is stalled, send a bubble down
      for (int s = 0; s < GROUP_WIDTH; s++) begin
        o_query_regs[s]   <= REGS_CLEAR;
        o_query_rename[s] <= 1'b0;
        o_pass[s]         <= INSTR_CLEAR;
      end
      o_query_tag <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rename_top.sv ====
// top of the rename slice, ties stage, alias table, free list and the dispatch credit counter to ports
`timescale 1ns/1ps
`default_nettype none

module rename_top (
  input  wire                                i_clock,
  input  wire                                i_reset,
  input  wire                                i_valid     [rename_pkg::GROUP_WIDTH],
  input  wire [31:0]                         i_address   [rename_pkg::GROUP_WIDTH],
  input  wire [31:0]                         i_immediate [rename_pkg::GROUP_WIDTH],
  input  wire rename_pkg::instr_class_t      i_class     [rename_pkg::GROUP_WIDTH],
  input  wire [rename_pkg::AREG_W-1:0]       i_rd        [rename_pkg::GROUP_WIDTH],
  input  wire [rename_pkg::AREG_W-1:0]       i_rs1       [rename_pkg::GROUP_WIDTH],
  input  wire [rename_pkg::AREG_W-1:0]       i_rs2       [rename_pkg::GROUP_WIDTH],
  input  wire                                i_writes    [rename_pkg::GROUP_WIDTH],
  input  wire                                i_jumps     [rename_pkg::GROUP_WIDTH],
  input  wire                                i_tag,
  input  wire                                i_credit_return,
  input  wire                                i_free_valid,
  input  wire [rename_pkg::PREG_W-1:0]       i_free_preg,
  output logic                               o_ready,
  output logic                               o_out_valid,
  output logic                               o_branch,
  output logic                               o_tag,
  output logic                               o_slot_valid [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::PREG_W-1:0]      o_prd        [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::PREG_W-1:0]      o_prs1       [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::PREG_W-1:0]      o_prs2       [rename_pkg::GROUP_WIDTH],
  output logic [rename_pkg::PREG_W-1:0]      o_old_prd    [rename_pkg::GROUP_WIDTH],
  output rename_pkg::instr_class_t           o_class      [rename_pkg::GROUP_WIDTH]
);
  import rename_pkg::*;

  instr_info_if group_if ();

  arch_regs_t             query_regs [GROUP_WIDTH];
  logic [GROUP_WIDTH-1:0] query_rename;
  logic                   query_tag;
  instr_info_t            pass [GROUP_WIDTH];
  logic [PREG_W-1:0]      alloc_preg [GROUP_WIDTH];
  logic [PREG_W-1:0]      prs1 [GROUP_WIDTH];
  logic [PREG_W-1:0]      prs2 [GROUP_WIDTH];
  logic [PREG_W-1:0]      old_prd [GROUP_WIDTH];
  logic [PREG_W:0]        free_count;
  logic [CREDIT_W-1:0]    credit_q;
  logic                   credit_ok;
  logic                   group_taken;
  renamed_t               out_q [GROUP_WIDTH];
  logic                   tag_q;

  always_comb begin
    for (int s = 0; s < GROUP_WIDTH; s++) begin
      group_if.slot[s].valid       = i_valid[s];
      group_if.slot[s].address     = i_address[s];
      group_if.slot[s].immediate   = i_immediate[s];
      group_if.slot[s].instr_class = i_class[s];
      group_if.slot[s].regs.rd     = i_rd[s];
      group_if.slot[s].regs.rs1    = i_rs1[s];
      group_if.slot[s].regs.rs2    = i_rs2[s];
      group_if.slot[s].writes      = i_writes[s];
      group_if.slot[s].jumps       = i_jumps[s];
    end
  end
  assign group_if.tag = i_tag;

  rename_stage stage_i (
    .i_clock(i_clock), .i_reset(i_reset), .i_free_count(free_count),
    .i_credit_ok(credit_ok), .i_group(group_if.snk), .o_ready(o_ready),
    .o_query_regs(query_regs), .o_query_rename(query_rename),
    .o_query_tag(query_tag), .o_pass(pass)
  );

  alias_table rat_i (
    .i_clock(i_clock), .i_reset(i_reset), .i_query_regs(query_regs),
    .i_query_rename(query_rename), .i_alloc_preg(alloc_preg),
    .o_prs1(prs1), .o_prs2(prs2), .o_old_prd(old_prd)
  );

  free_list free_i (
    .i_clock(i_clock), .i_reset(i_reset), .i_pop(query_rename),
    .i_push(i_free_valid), .i_push_preg(i_free_preg),
    .o_alloc_preg(alloc_preg), .o_count(free_count)
  );

  //////////////////////////////////////////////////////////////////////
  // dispatch credits, taken when a group is accepted
  //////////////////////////////////////////////////////////////////////

  assign group_taken = o_ready && (i_valid[0] || i_valid[1]);
  assign credit_ok   = credit_q != '0;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      credit_q <= CREDIT_MAX[CREDIT_W-1:0];
    end else begin
      case ({group_taken, i_credit_return})
        2'b10: credit_q <= credit_q - CREDIT_W'(1);
        2'b01: begin
          if (credit_q != CREDIT_MAX[CREDIT_W-1:0]) begin
            credit_q <= credit_q + CREDIT_W'(1);  // extra returns are ignored
          end
        end
        default: credit_q <= credit_q;  // both or neither cancel out
      endcase
    end
  end

  // output group, fields from the stage merged with the map lookup
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int s = 0; s < GROUP_WIDTH; s++) begin
        out_q[s] <= RENAMED_CLEAR;
      end
      tag_q <= 1'b0;
    end else begin
      for (int s = 0; s < GROUP_WIDTH; s++) begin
        out_q[s].valid       <= pass[s].valid;
        out_q[s].address     <= pass[s].address;
        out_q[s].immediate   <= pass[s].immediate;
        out_q[s].instr_class <= pass[s].instr_class;
        out_q[s].prd         <= query_rename[s] ? alloc_preg[s] : '0;
        out_q[s].prs1        <= prs1[s];
        out_q[s].prs2        <= prs2[s];
        out_q[s].old_prd     <= old_prd[s];
        out_q[s].writes      <= pass[s].writes;
        out_q[s].jumps       <= pass[s].jumps;
      end
      tag_q <= query_tag;
    end
  end

  assign o_out_valid = out_q[0].valid || out_q[1].valid;
  assign o_branch    = (out_q[0].valid && out_q[0].jumps) || (out_q[1].valid && out_q[1].jumps);
  assign o_tag       = tag_q;

  always_comb begin
    for (int s = 0; s < GROUP_WIDTH; s++) begin
      o_slot_valid[s] = out_q[s].valid;
      o_prd[s]        = out_q[s].prd;
      o_prs1[s]       = out_q[s].prs1;
      o_prs2[s]       = out_q[s].prs2;
      o_old_prd[s]    = out_q[s].old_prd;
      o_class[s]      = out_q[s].instr_class;
    end
  end

endmodule

`default_nettype wire
